//--- videoPixelGen.f
source/videoPixelPkg.sv
source/syncFifo.sv
source/pixelDrawPosition.sv
source/sceneChange.sv
source/dotMergeToPixel.sv
source/videoPixelGen.sv
tb/videoPixelGen_asserts.sv
tb/videoPixelGenTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the videoPixelGen testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module videoPixelGenTb \
	-f videoPixelGen.f \
	-o simv

status=0
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"

//--- tb/videoPixelGenTb.sv
/*
 Testbench for videoPixelGen, one reset per table row.
 Display size stays fixed within a row, iCke is random at the row duty.
 Expected pixels come from a raster walk over frames and tiles.
*/
`timescale 1ns/1ps
`default_nettype none

module videoPixelGenTb;

	// Cycles allowed for a single pixel
	localparam int PixelTimeout = 2000;
	localparam int RowCount     = 4;

	typedef struct packed {
		logic [videoPixelPkg::HdisplayWidth-1:0] hDisp;
		logic [videoPixelPkg::VdisplayWidth-1:0] vDisp;
		logic [videoPixelPkg::ColorDepth-1:0]    color;
		logic [videoPixelPkg::OutColorDepth-1:0] back;
		logic [7:0]                              duty;
		logic [7:0]                              frames;
	} rowType;

	logic                                    iClk;
	logic                                    reset;
	logic [videoPixelPkg::HdisplayWidth-1:0] iHdisplay;
	logic [videoPixelPkg::VdisplayWidth-1:0] iVdisplay;
	logic [videoPixelPkg::ColorDepth-1:0]    iColor;
	logic [videoPixelPkg::OutColorDepth-1:0] iBackColor;
	logic                                    iCke;
	logic [videoPixelPkg::OutColorDepth-1:0] oPixel;
	logic                                    oWEd;

	rowType                                  rows [RowCount];
	// Frame ends seen at the position counter since reset
	int                                      frameEnds;

	always #4 iClk = ~iClk;

	videoPixelGen dut (
		.iClk       (iClk),
		.reset      (reset),
		.iHdisplay  (iHdisplay),
		.iVdisplay  (iVdisplay),
		.iColor     (iColor),
		.iBackColor (iBackColor),
		.iCke       (iCke),
		.oPixel     (oPixel),
		.oWEd       (oWEd)
	);

	// Count frame boundaries of the raster walk
	always @(posedge iClk)
	begin
		if (reset)
			frameEnds <= 0;
		else if (dut.frameEnd)
			frameEnds <= frameEnds + 1;
	end

	// -------------------------------------------------------------------------
	// Failure and compare tasks
	// -------------------------------------------------------------------------
	task automatic failNow(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopping on first error");
	endtask

	task automatic checkPixel(input logic [videoPixelPkg::OutColorDepth-1:0] actual,
		input logic [videoPixelPkg::OutColorDepth-1:0] expected, input string what);
		if (actual !== expected)
			failNow($sformatf("[ERROR] %0t: %s pixel expected %03h got %03h",
				$time, what, expected, actual));
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		if (actual != expected)
			failNow($sformatf("[ERROR] %0t: %s expected %0d got %0d",
				$time, what, expected, actual));
	endtask

	task automatic checkStrobe(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			failNow($sformatf("[ERROR] %0t: %s expected %b got %b",
				$time, what, expected, actual));
	endtask

	// Bound assertion failures end the run at once
	always @(negedge iClk)
	begin
		if (dut.checks.failCount != 0)
			failNow("A bound assertion failed, see the message above");
	end

	// -------------------------------------------------------------------------
	// Reference model
	// -------------------------------------------------------------------------
	// Step moves at the frame boundary, so the whole frame shares one step
	function automatic logic [videoPixelPkg::OutColorDepth-1:0] expectedPixel(input int h,
		input int v, input int frame, input logic [videoPixelPkg::ColorDepth-1:0] color,
		input logic [videoPixelPkg::OutColorDepth-1:0] back);
		int   step;
		logic lit;
		step = (frame < videoPixelPkg::TileSize) ? frame : videoPixelPkg::TileSize;
		lit  = ((h % videoPixelPkg::TileSize) < step) && ((v % videoPixelPkg::TileSize) < step);
		// Zero alpha lets the background through
		if (lit && (color[videoPixelPkg::ColorDepth-1:videoPixelPkg::OutColorDepth] != '0))
			return color[videoPixelPkg::OutColorDepth-1:0];
		return back;
	endfunction

	// -------------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------------
	// Reset with iCke low, sizes applied during reset
	task automatic applyReset(input rowType row);
		@(negedge iClk);
		reset      = 1'b1;
		iCke       = 1'b0;
		iHdisplay  = row.hDisp;
		iVdisplay  = row.vDisp;
		iColor     = row.color;
		iBackColor = row.back;
		repeat (10)
		begin
			@(negedge iClk);
			checkStrobe(oWEd, 1'b0, "oWEd during reset");
		end
		reset = 1'b0;
	endtask

	// Sample outputs then redraw iCke, once per falling edge
	task automatic nextPixel(input int duty,
		output logic [videoPixelPkg::OutColorDepth-1:0] pix);
		int   waited;
		logic got;
		waited = 0;
		got    = 1'b0;
		while (!got)
		begin
			@(negedge iClk);
			if (oWEd === 1'b1)
			begin
				got = 1'b1;
				pix = oPixel;
			end
			iCke = (($urandom % 100) < duty);
			waited++;
			if (!got && waited > PixelTimeout)
				failNow($sformatf("Timed out at %0t waiting for oWEd", $time));
		end
	endtask

	task automatic runRow(input rowType row);
		logic [videoPixelPkg::OutColorDepth-1:0] pix;
		logic [videoPixelPkg::OutColorDepth-1:0] expected;
		applyReset(row);
		for (int f = 0; f < int'(row.frames); f++)
		begin
			for (int v = 0; v < int'(row.vDisp); v++)
			begin
				for (int h = 0; h < int'(row.hDisp); h++)
				begin
					nextPixel(int'(row.duty), pix);
					expected = expectedPixel(h, v, f, row.color, row.back);
					checkPixel(pix, expected, $sformatf("frame %0d at (%0d,%0d)", f, h, v));
				end
			end
			// Width times height pixels out per frame end of the position counter
			checkCount(frameEnds, f + 1, "frames ended");
		end
	endtask

	// -------------------------------------------------------------------------
	// Main sequence
	// -------------------------------------------------------------------------
	initial
	begin
		iClk       = 1'b0;
		reset      = 1'b1;
		iHdisplay  = '0;
		iVdisplay  = '0;
		iColor     = '0;
		iBackColor = '0;
		iCke       = 1'b0;
		void'($urandom(73));

		// Width, height, color, background, duty, frames
		rows[0] = '{11'd20, 11'd18, 16'hF5A3, 12'h123, 8'd100, 8'd18};
		// Same picture under random back-pressure
		rows[1] = '{11'd20, 11'd18, 16'hF5A3, 12'h123, 8'd30, 8'd18};
		rows[2] = '{11'd33, 11'd17, 16'h0ABC, 12'h5E7, 8'd100, 8'd3};
		rows[3] = '{11'd37, 11'd20, 16'h8FFF, 12'h000, 8'd70, 8'd4};

		for (int r = 0; r < RowCount; r++)
			runRow(rows[r]);

		// Consumer never reads, nothing may come out
		applyReset(rows[0]);
		repeat (200)
		begin
			@(negedge iClk);
			checkStrobe(oWEd, 1'b0, "oWEd with iCke held low");
		end

		if (dut.checks.failCount == 0)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
		begin
			failNow($sformatf("%0d assertion failures in the bound checks",
				dut.checks.failCount));
		end
	end

endmodule

`default_nettype wire

//--- tb/videoPixelGen_asserts.sv
/*
 Concurrent checks bound into videoPixelGen.
 FIFO checks compare the strobes with the occupancy count inside each FIFO.
 failCount tells the testbench that an assertion has failed.
*/
`timescale 1ns/1ps
`default_nettype none

module videoPixelGen_asserts (
	input wire                                     iClk,
	input wire                                     reset,
	input wire                                     oWEd,
	input wire [videoPixelPkg::HdisplayWidth-1:0]  hPos,
	input wire [videoPixelPkg::HdisplayWidth-1:0]  hLast,
	input wire                                     posCke,
	input wire                                     sceneRead,
	input wire                                     sceneValid,
	input wire                                     pixelRead,
	input wire [videoPixelPkg::FifoCountWidth-1:0] sceneCount,
	input wire [videoPixelPkg::FifoCountWidth-1:0] pixelCount
);

	int failCount = 0;

	// -------------------------------------------------------------------------
	// FIFO strobes
	// -------------------------------------------------------------------------
	// Position advance writes a dot, needs a free slot
	sceneWriteFull: assert property (@(posedge iClk) disable iff (reset)
		posCke |-> (sceneCount < videoPixelPkg::FifoDepth))
		else begin failCount++; $error("scene FIFO written while full"); end

	sceneReadEmpty: assert property (@(posedge iClk) disable iff (reset)
		sceneRead |-> (sceneCount != '0))
		else begin failCount++; $error("scene FIFO read while empty"); end

	// Merged dot lands in the pixel FIFO on the scene valid pulse
	pixelWriteFull: assert property (@(posedge iClk) disable iff (reset)
		sceneValid |-> (pixelCount < videoPixelPkg::FifoDepth))
		else begin failCount++; $error("pixel FIFO written while full"); end

	pixelReadEmpty: assert property (@(posedge iClk) disable iff (reset)
		pixelRead |-> (pixelCount != '0))
		else begin failCount++; $error("pixel FIFO read while empty"); end

	// -------------------------------------------------------------------------
	// Position and output
	// -------------------------------------------------------------------------
	hPosRange: assert property (@(posedge iClk) disable iff (reset)
		hPos <= hLast)
		else begin failCount++; $error("hPos beyond last column"); end

	// Output strobe cleared by the first reset edge
	wedInReset: assert property (@(posedge iClk)
		reset |=> !oWEd)
		else begin failCount++; $error("oWEd high during reset"); end

endmodule

bind videoPixelGen videoPixelGen_asserts checks (
	.iClk       (iClk),
	.reset      (reset),
	.oWEd       (oWEd),
	.hPos       (hPos),
	.hLast      (hLast),
	.posCke     (posCke),
	.sceneRead  (sceneRead),
	.sceneValid (sceneValid),
	.pixelRead  (pixelRead),
	.sceneCount (scene.dotFifo.count),
	.pixelCount (merge.pixelFifo.count)
);

`default_nettype wire

//--- source/videoPixelGen.sv
/*
 Pixel generator top, one scene layer over a background color.
 iHdisplay and iVdisplay must be steady from reset on.
 oWEd marks each 12-bit pixel, read out while iCke is high.
*/
`timescale 1ns/1ps
`default_nettype none

module videoPixelGen (
	input  wire                                     iClk,
	input  wire                                     reset,
	input  wire  [videoPixelPkg::HdisplayWidth-1:0] iHdisplay,
	input  wire  [videoPixelPkg::VdisplayWidth-1:0] iVdisplay,
	input  wire  [videoPixelPkg::ColorDepth-1:0]    iColor,
	input  wire  [videoPixelPkg::OutColorDepth-1:0] iBackColor,
	input  wire                                     iCke,
	output logic [videoPixelPkg::OutColorDepth-1:0] oPixel,
	output logic                                    oWEd
);

	//--------------------------------------------------------------------------
	// Display size registers
	//--------------------------------------------------------------------------
	logic [videoPixelPkg::HdisplayWidth-1:0] hLast;
	logic [videoPixelPkg::VdisplayWidth-1:0] vLast;

	// Last column and row, one cycle after the inputs
	always_ff @(posedge iClk)
	begin
		hLast <= iHdisplay - 1'b1;
		vLast <= iVdisplay - 1'b1;
	end

	//--------------------------------------------------------------------------
	// Shared raster position
	//--------------------------------------------------------------------------
	logic [videoPixelPkg::HdisplayWidth-1:0] hPos;
	logic [videoPixelPkg::VdisplayWidth-1:0] vPos;
	logic                                    frameEnd;
	logic                                    posCke;

	pixelDrawPosition position (
		.iClk      (iClk),
		.reset     (reset),
		.iCke      (posCke),
		.iHlast    (hLast),
		.iVlast    (vLast),
		.oHpos     (hPos),
		.oVpos     (vPos),
		.oFrameEnd (frameEnd)
	);

	//--------------------------------------------------------------------------
	// Scene change layer
	//--------------------------------------------------------------------------
	logic                                 sceneFull;
	logic                                 sceneRead;
	logic [videoPixelPkg::ColorDepth-1:0] sceneDot;
	logic                                 sceneValid;
	logic                                 sceneEmpty;

	// Position holds whenever the layer FIFO has no room
	assign posCke = ~sceneFull;

	sceneChange scene (
		.iClk      (iClk),
		.reset     (reset),
		.iWrite    (posCke),
		.iHpos     (hPos),
		.iVpos     (vPos),
		.iFrameEnd (frameEnd),
		.iColor    (iColor),
		.oFull     (sceneFull),
		.iRead     (sceneRead),
		.oDot      (sceneDot),
		.oValid    (sceneValid),
		.oEmpty    (sceneEmpty)
	);

	//--------------------------------------------------------------------------
	// Merge stage and output
	//--------------------------------------------------------------------------
	logic mergeFull;
	logic mergeEmpty;
	logic pixelRead;

	// Move a dot when one is buffered and the merge can take it
	assign sceneRead = ~sceneEmpty & ~mergeFull;
	// Consumer strobe pulls the next pixel
	assign pixelRead = ~mergeEmpty & iCke;

	dotMergeToPixel merge (
		.iClk       (iClk),
		.reset      (reset),
		.iDot       (sceneDot),
		.iDotValid  (sceneValid),
		.iBackColor (iBackColor),
		.oFull      (mergeFull),
		.iRead      (pixelRead),
		.oPixel     (oPixel),
		.oValid     (oWEd),
		.oEmpty     (mergeEmpty)
	);

endmodule

`default_nettype wire

//--- source/dotMergeToPixel.sv
/*
 Merges the layer dot over a background color and drops the alpha.
 oFull also covers the dot in flight, so at most one read is pending.
*/
`timescale 1ns/1ps
`default_nettype none

module dotMergeToPixel (
	input  wire                                     iClk,
	input  wire                                     reset,
	input  wire  [videoPixelPkg::ColorDepth-1:0]    iDot,
	input  wire                                     iDotValid,
	input  wire  [videoPixelPkg::OutColorDepth-1:0] iBackColor,
	output logic                                    oFull,
	input  wire                                     iRead,
	output logic [videoPixelPkg::OutColorDepth-1:0] oPixel,
	output logic                                    oValid,
	output logic                                    oEmpty
);

	logic [videoPixelPkg::AlphaWidth-1:0]    alpha;
	logic [videoPixelPkg::OutColorDepth-1:0] merged;
	logic                                    pixelFull;

	//--------------------------------------------------------------------------
	// Alpha select
	//--------------------------------------------------------------------------
	// Alpha nibble sits above the RGB bits
	assign alpha = iDot[videoPixelPkg::ColorDepth-1:videoPixelPkg::OutColorDepth];

	// Any nonzero alpha counts as opaque
	assign merged = (alpha != '0) ? iDot[videoPixelPkg::OutColorDepth-1:0] : iBackColor;

	// Busy while the pixel FIFO is full or a dot is arriving this cycle
	// (the in-flight dot needs a free slot too)
	assign oFull = pixelFull | iDotValid;

	// Pixel output buffer
	syncFifo #(
		.payloadType (logic [videoPixelPkg::OutColorDepth-1:0])
	) pixelFifo (
		.iClk   (iClk),
		.reset  (reset),
		.iWrite (iDotValid),
		.iData  (merged),
		.oFull  (pixelFull),
		.iRead  (iRead),
		.oData  (oPixel),
		.oValid (oValid),
		.oEmpty (oEmpty)
	);

endmodule

`default_nettype wire

//--- source/sceneChange.sv
/*
 Dot wipe scene layer, one dot per iWrite into its own FIFO.
 The square grows one pixel per frame in every tile, up to TileSize.
 The step updates after frameEnd, so the last dot keeps the old step.
*/
`timescale 1ns/1ps
`default_nettype none

module sceneChange (
	input  wire                                     iClk,
	input  wire                                     reset,
	input  wire                                     iWrite,
	input  wire  [videoPixelPkg::HdisplayWidth-1:0] iHpos,
	input  wire  [videoPixelPkg::VdisplayWidth-1:0] iVpos,
	input  wire                                     iFrameEnd,
	input  wire  [videoPixelPkg::ColorDepth-1:0]    iColor,
	output logic                                    oFull,
	input  wire                                     iRead,
	output logic [videoPixelPkg::ColorDepth-1:0]    oDot,
	output logic                                    oValid,
	output logic                                    oEmpty
);

	logic [videoPixelPkg::StepWidth-1:0]  step;
	logic [videoPixelPkg::TileBits-1:0]   hTile;
	logic [videoPixelPkg::TileBits-1:0]   vTile;
	logic                                 lit;
	logic [videoPixelPkg::ColorDepth-1:0] dot;

	//--------------------------------------------------------------------------
	// Frame counter doubling as wipe step
	//--------------------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			step <= '0;
		end
		// Saturate once the square covers the whole tile
		else if (iFrameEnd &&
			(step != videoPixelPkg::StepWidth'(videoPixelPkg::TileSize)))
		begin
			step <= step + 1'b1;
		end
	end

	//--------------------------------------------------------------------------
	// Tile membership per dot
	//--------------------------------------------------------------------------
	// Position within tile, low bits only
	assign hTile = iHpos[videoPixelPkg::TileBits-1:0];
	assign vTile = iVpos[videoPixelPkg::TileBits-1:0];

	// Lit inside the top left square of side step
	assign lit = ({1'b0, hTile} < step) & ({1'b0, vTile} < step);

	// Unlit dot is all zero, alpha 0 means transparent
	assign dot = lit ? iColor : '0;

	// Layer output buffer
	syncFifo #(
		.payloadType (logic [videoPixelPkg::ColorDepth-1:0])
	) dotFifo (
		.iClk   (iClk),
		.reset  (reset),
		.iWrite (iWrite),
		.iData  (dot),
		.oFull  (oFull),
		.iRead  (iRead),
		.oData  (oDot),
		.oValid (oValid),
		.oEmpty (oEmpty)
	);

endmodule

`default_nettype wire

//--- source/pixelDrawPosition.sv
/*
 Raster position counter, advances only while iCke is high.
 iHlast and iVlast are the last column and row and must be steady.
 oFrameEnd is combinational on the last position with iCke high.
*/
`timescale 1ns/1ps
`default_nettype none

module pixelDrawPosition (
	input  wire                                     iClk,
	input  wire                                     reset,
	input  wire                                     iCke,
	input  wire  [videoPixelPkg::HdisplayWidth-1:0] iHlast,
	input  wire  [videoPixelPkg::VdisplayWidth-1:0] iVlast,
	output logic [videoPixelPkg::HdisplayWidth-1:0] oHpos,
	output logic [videoPixelPkg::VdisplayWidth-1:0] oVpos,
	output logic                                    oFrameEnd
);

	logic hLastHit;
	logic vLastHit;

	// End of line and end of frame detection
	assign hLastHit  = (oHpos == iHlast);
	assign vLastHit  = (oVpos == iVlast);
	assign oFrameEnd = iCke & hLastHit & vLastHit;

	//--------------------------------------------------------------------------
	// Horizontal then vertical count
	//--------------------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			oHpos <= '0;
			oVpos <= '0;
		end
		else if (iCke)
		begin
			if (hLastHit)
			begin
				oHpos <= '0;
				// Wrap to top of screen after last row
				if (vLastHit)
					oVpos <= '0;
				else
					oVpos <= oVpos + 1'b1;
			end
			else
			begin
				oHpos <= oHpos + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/syncFifo.sv
/*
 Single clock FIFO, FifoDepth entries, depth a power of two.
 Read data appears one cycle after iRead together with an oValid pulse.
 Writes while full and reads while empty are dropped.
*/
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
	parameter type payloadType = logic [videoPixelPkg::ColorDepth-1:0]
) (
	input  wire        iClk,
	input  wire        reset,
	input  wire        iWrite,
	input  wire payloadType iData,
	output logic       oFull,
	input  wire        iRead,
	output payloadType oData,
	output logic       oValid,
	output logic       oEmpty
);

	// Storage array, no reset needed
	payloadType mem [videoPixelPkg::FifoDepth];

	logic [videoPixelPkg::FifoAddrWidth-1:0]  wrPtr;
	logic [videoPixelPkg::FifoAddrWidth-1:0]  rdPtr;
	logic [videoPixelPkg::FifoCountWidth-1:0] count;
	logic [videoPixelPkg::FifoCountWidth-1:0] countNext;
	logic                                     doWrite;
	logic                                     doRead;

	// Qualified strobes
	assign doWrite = iWrite & ~oFull;
	assign doRead  = iRead & ~oEmpty;

	// Occupancy after this cycle
	assign countNext = count
		+ videoPixelPkg::FifoCountWidth'(doWrite)
		- videoPixelPkg::FifoCountWidth'(doRead);

	//--------------------------------------------------------------------------
	// Pointers, count and status flags
	//--------------------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			oFull  <= 1'b0;
			oEmpty <= 1'b1;
			oValid <= 1'b0;
		end
		else
		begin
			// Pointers wrap naturally at the power-of-two depth
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			count  <= countNext;
			oFull  <= (countNext == videoPixelPkg::FifoCountWidth'(videoPixelPkg::FifoDepth));
			oEmpty <= (countNext == '0);
			// Valid follows the accepted read by one cycle
			oValid <= doRead;
		end
	end

	// Array write and registered read port
	always_ff @(posedge iClk)
	begin
		if (doWrite)
			mem[wrPtr] <= iData;
		if (doRead)
			oData <= mem[rdPtr];
	end

endmodule

`default_nettype wire

//--- source/videoPixelPkg.sv
/*
 Shared widths and sizes for the pixel generation RTL.
 TileSize and FifoDepth must be powers of two.
*/
`default_nettype none

package videoPixelPkg;

	//--------------------------------------------------------------------------
	// Display geometry
	//--------------------------------------------------------------------------
	// 11 bits covers up to 2048 pixels per axis
	localparam int HdisplayWidth = 11;
	localparam int VdisplayWidth = 11;

	//--------------------------------------------------------------------------
	// Color formats
	//--------------------------------------------------------------------------
	// Layer dot is ARGB 4:4:4:4 with alpha on top
	localparam int ColorDepth    = 16;
	// Output pixel is RGB 4:4:4
	localparam int OutColorDepth = 12;
	localparam int AlphaWidth    = ColorDepth - OutColorDepth;

	// Dot wipe tile edge and saturating step
	localparam int TileSize  = 16;
	localparam int TileBits  = $clog2(TileSize);
	localparam int StepWidth = TileBits + 1;

	// Both stage FIFOs
	localparam int FifoDepth      = 16;
	localparam int FifoAddrWidth  = $clog2(FifoDepth);
	localparam int FifoCountWidth = FifoAddrWidth + 1;

endpackage

`default_nettype wire
